// ==== mem_cfg.svh ====
/*
 * Memory subsystem configuration
 * Bank count, bank depth and AXI byte address width
 */
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// ------------------------------------------------
// Geometry
// ------------------------------------------------

// Byte lanes in one AXI word
`define MEM_BANKS 4

// Words per byte-lane bank
`define MEM_DEPTH 1024

// AXI byte address bits, 4 KB window
`define MEM_AXI_AW 12

`endif

// ==== mem_pkg.sv ====
/*
 * Memory subsystem package
 * Vector types, the per-cycle bank request and the arbiter
 * state encoding shared by the front end, banks and top level
 */
`include "mem_cfg.svh"

package mem_pkg;

    // ------------------------------------------------
    // Data and address vectors
    // ------------------------------------------------

    // One byte lane as stored in a bank
    typedef logic [7:0] byte_t;

    // Full AXI data word, one byte per bank
    typedef logic [`MEM_BANKS*8-1:0] word_t;

    // AXI byte address
    typedef logic [`MEM_AXI_AW-1:0] axi_addr_t;

    // Word index inside a bank, AXI address bits 11..2
    typedef logic [$clog2(`MEM_DEPTH)-1:0] bank_addr_t;

    // Byte strobe, also the per-bank write enables
    typedef logic [`MEM_BANKS-1:0] strb_t;

    // AXI response code
    typedef logic [1:0] axi_resp_t;

    // No error responses in this design
    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    // ------------------------------------------------
    // Bank request, broadcast to all lanes each cycle
    // ------------------------------------------------
    typedef struct packed {
        strb_t      wen;
        logic       ren;
        bank_addr_t addr;
        word_t      wdata;
    } bank_req_t;

    // Arbiter FSM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WRITE,
        ARB_READ,
        ARB_WAIT_B
    } arb_state_t;

endpackage

// ==== sram_sp_1024x8.sv ====
/*
 * Single-port SRAM macro model, 1024 x 8
 * Behavioral stand-in for the vendor macro without BIST pins.
 * Synchronous write, registered read output that holds between reads
 */
`include "mem_cfg.svh"

module sram_sp_1024x8 (
    input  logic                clk,
    input  logic                men,
    input  logic                wen,
    input  logic                ren,
    input  mem_pkg::bank_addr_t addr,
    input  mem_pkg::byte_t      din,
    output mem_pkg::byte_t      dout
);
    import mem_pkg::*;

    // ------------------------------------------------
    // Storage array
    // ------------------------------------------------

    // One byte per word index
    byte_t mem [`MEM_DEPTH];

    // Decoded macro operations
    logic do_write;
    logic do_read;

    // Macro enable gates both operations
    assign do_write = men & wen;
    assign do_read  = men & ren;

    // ------------------------------------------------
    // Write port
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[addr] <= din;
        end
    end

    // ------------------------------------------------
    // Read port
    // ------------------------------------------------

    // One cycle latency from ren to dout
    // Output register keeps last read value when idle
    always_ff @(posedge clk) begin
        if (do_read) begin
            dout <= mem[addr];
        end
    end

endmodule

// ==== dpram_1024x8.sv ====
/*
 * Byte-lane bank, 1024 x 8
 * Separate write and read ports mapped onto one single-port macro
 */

module dpram_1024x8 (
    input  logic                clk,
    input  logic                wen,
    input  logic                ren,
    input  mem_pkg::bank_addr_t waddr,
    input  mem_pkg::bank_addr_t raddr,
    input  mem_pkg::byte_t      data_in,
    output mem_pkg::byte_t      data_out
);
    import mem_pkg::*;

    // Shared macro controls
    logic       mac_men;
    bank_addr_t mac_addr;

    // ------------------------------------------------
    // Port merge
    // ------------------------------------------------

    // Macro active when either port is used
    assign mac_men = wen | ren;

    // Write address while writing, read address otherwise
    assign mac_addr = wen ? waddr : raddr;

    // Single-port macro
    sram_sp_1024x8 u_sram (
        .clk  (clk),
        .men  (mac_men),
        .wen  (wen),
        .ren  (ren),
        .addr (mac_addr),
        .din  (data_in),
        .dout (data_out)
    );

endmodule

// ==== axil_req_arbiter.sv ====
/*
 * AXI4-Lite request arbiter
 * Accepts AW/W pairs and AR requests with writes ahead of reads,
 * and registers one bank request per cycle. Owns the B channel
 */

module axil_req_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    // Write address channel
    input  logic                aw_valid,
    output logic                aw_ready,
    input  mem_pkg::axi_addr_t  aw_addr,
    // Write data channel
    input  logic                w_valid,
    output logic                w_ready,
    input  mem_pkg::word_t      w_data,
    input  mem_pkg::strb_t      w_strb,
    // Write response channel
    output logic                b_valid,
    input  logic                b_ready,
    output mem_pkg::axi_resp_t  b_resp,
    // Read address channel
    input  logic                ar_valid,
    output logic                ar_ready,
    input  mem_pkg::axi_addr_t  ar_addr,
    // From the read return path
    input  logic                r_busy,
    // To the banks
    output mem_pkg::bank_req_t  bank_req,
    output logic                rd_issue
);
    import mem_pkg::*;

    arb_state_t state_q;
    arb_state_t state_d;

    // Handshake decode
    logic wr_pair;
    logic wr_fire;
    logic rd_fire;

    // Registered request fields
    strb_t      req_wen;
    logic       req_ren;
    bank_addr_t req_addr;
    word_t      req_wdata;

    // ------------------------------------------------
    // Channel handshakes
    // ------------------------------------------------

    // AW and W are only taken together
    assign wr_pair = aw_valid & w_valid;

    // Write needs idle FSM and no pending response
    assign wr_fire  = (state_q == ARB_IDLE) & wr_pair & ~b_valid;
    assign aw_ready = wr_fire;
    assign w_ready  = wr_fire;

    // Read yields to a full write pair
    assign ar_ready = (state_q == ARB_IDLE) & ~r_busy & ~wr_pair;
    assign rd_fire  = ar_valid & ar_ready;

    assign b_resp = AXI_RESP_OKAY;

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (wr_fire) begin
                    state_d = ARB_WRITE;
                end else if (rd_fire) begin
                    state_d = ARB_READ;
                end
            end
            // Bank write in flight
            ARB_WRITE:  state_d = ARB_WAIT_B;
            // Bank read in flight, data tracked by r_busy
            ARB_READ:   state_d = ARB_IDLE;
            ARB_WAIT_B: begin
                if (b_ready) begin
                    state_d = ARB_IDLE;
                end
            end
            default:    state_d = ARB_IDLE;
        endcase
    end

    // State, enables and B valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ARB_IDLE;
            req_wen <= '0;
            req_ren <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            state_q <= state_d;
            // Strobes map straight onto lane enables
            req_wen <= wr_fire ? w_strb : '0;
            req_ren <= rd_fire;
            // Response once the banks hold the data
            if (state_q == ARB_WRITE) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------
    // Request payload
    // ------------------------------------------------

    // Word index drops the two byte offset bits
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            req_addr  <= bank_addr_t'(aw_addr >> 2);
            req_wdata <= w_data;
        end else if (rd_fire) begin
            req_addr  <= bank_addr_t'(ar_addr >> 2);
        end
    end

    assign bank_req = '{wen: req_wen, ren: req_ren, addr: req_addr, wdata: req_wdata};

    // Read strobe doubles as the issue marker
    assign rd_issue = req_ren;

endmodule

// ==== axil_read_return.sv ====
/*
 * AXI4-Lite read return
 * Captures the bank bytes one cycle after a read is issued,
 * packs them into a word and holds R until the master takes it
 */
`include "mem_cfg.svh"

module axil_read_return (
    input  logic                                clk,
    input  logic                                rst_n,
    // Byte outputs of the banks
    input  mem_pkg::byte_t [`MEM_BANKS-1:0]     bank_rdata,
    input  logic                                rd_issue,
    // Read data channel
    output logic                                r_valid,
    input  logic                                r_ready,
    output mem_pkg::word_t                      r_data,
    output mem_pkg::axi_resp_t                  r_resp,
    // Back to the arbiter
    output logic                                r_busy
);
    import mem_pkg::*;

    localparam int LANE_W = $bits(byte_t);

    // Macro output valid in this cycle
    logic  cap_pending;
    word_t rd_word;

    // ------------------------------------------------
    // Lane gather
    // ------------------------------------------------

    // Bank i lands in byte i
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < `MEM_BANKS; i++) begin
            rd_word[i*LANE_W +: LANE_W] = bank_rdata[i];
        end
    end

    // ------------------------------------------------
    // R channel control
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cap_pending <= 1'b0;
            r_valid     <= 1'b0;
        end else begin
            // Match the one cycle macro latency
            cap_pending <= rd_issue;
            if (cap_pending) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Data register, held under back-pressure
    always_ff @(posedge clk) begin
        if (cap_pending) begin
            r_data <= rd_word;
        end
    end

    assign r_resp = AXI_RESP_OKAY;

    // Covers issue, capture and the wait for r_ready
    assign r_busy = rd_issue | cap_pending | r_valid;

endmodule

// ==== mem_subsys_top.sv ====
/*
 * AXI4-Lite word memory, 4 KB
 * Request arbiter, four byte-lane banks and the read return path
 */
`include "mem_cfg.svh"

module mem_subsys_top (
    input  logic                clk,
    input  logic                rst_n,
    // AW
    input  logic                aw_valid,
    output logic                aw_ready,
    input  mem_pkg::axi_addr_t  aw_addr,
    // W
    input  logic                w_valid,
    output logic                w_ready,
    input  mem_pkg::word_t      w_data,
    input  mem_pkg::strb_t      w_strb,
    // B
    output logic                b_valid,
    input  logic                b_ready,
    output mem_pkg::axi_resp_t  b_resp,
    // AR
    input  logic                ar_valid,
    output logic                ar_ready,
    input  mem_pkg::axi_addr_t  ar_addr,
    // R
    output logic                r_valid,
    input  logic                r_ready,
    output mem_pkg::word_t      r_data,
    output mem_pkg::axi_resp_t  r_resp
);
    import mem_pkg::*;

    localparam int LANE_W = $bits(byte_t);

    bank_req_t                   bank_req;
    byte_t [`MEM_BANKS-1:0]      bank_rdata;
    logic                        rd_issue;
    logic                        r_busy;

    // ------------------------------------------------
    // Front end
    // ------------------------------------------------
    axil_req_arbiter u_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_resp   (b_resp),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .r_busy   (r_busy),
        .bank_req (bank_req),
        .rd_issue (rd_issue)
    );

    // One bank per byte lane, same address on both ports
    for (genvar i = 0; i < `MEM_BANKS; i++) begin : g_bank
        dpram_1024x8 u_bank (
            .clk      (clk),
            .wen      (bank_req.wen[i]),
            .ren      (bank_req.ren),
            .waddr    (bank_req.addr),
            .raddr    (bank_req.addr),
            .data_in  (bank_req.wdata[i*LANE_W +: LANE_W]),
            .data_out (bank_rdata[i])
        );
    end

    // Read data back to AXI
    axil_read_return u_rret (
        .clk        (clk),
        .rst_n      (rst_n),
        .bank_rdata (bank_rdata),
        .rd_issue   (rd_issue),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r_data     (r_data),
        .r_resp     (r_resp),
        .r_busy     (r_busy)
    );

endmodule

// ==== tb_mem_subsys.sv ====
/*
 * Testbench for the AXI4-Lite word memory
 * Replays the testdata records, then random strobes with random
 * B and R back-pressure against a shadow model, then contention
 */
`include "mem_cfg.svh"

module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    localparam int CLK_HALF    = 4;
    localparam int RST_CYCLES  = 16;
    localparam int DRIVE_DLY   = 1;
    localparam int TIMEOUT_CYC = 64;
    localparam int MAX_RECS    = 32;
    localparam int REC_WORDS   = 5;
    localparam int N_RANDOM    = 12;
    // Edges from handshake to first valid sample
    localparam int B_LATENCY   = 2;
    localparam int R_LATENCY   = 3;
    localparam logic [15:0] LFSR_SEED = 16'd51;
    localparam logic [15:0] LFSR_TAPS = 16'hb400;
    localparam axi_resp_t   RESP_OKAY = 2'b00;
    localparam logic [31:0] OP_END    = 32'd0;
    localparam logic [31:0] OP_WRITE  = 32'd1;
    localparam logic [31:0] OP_READ   = 32'd2;

    // One line of the data file
    typedef struct packed {
        logic [31:0] op;
        axi_addr_t   addr;
        word_t       data;
        strb_t       strb;
        word_t       expected;
    } stim_rec_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      aw_valid;
    logic      aw_ready;
    axi_addr_t aw_addr;
    logic      w_valid;
    logic      w_ready;
    word_t     w_data;
    strb_t     w_strb;
    logic      b_valid;
    logic      b_ready;
    axi_resp_t b_resp;
    logic      ar_valid;
    logic      ar_ready;
    axi_addr_t ar_addr;
    logic      r_valid;
    logic      r_ready;
    word_t     r_data;
    axi_resp_t r_resp;

    logic [31:0] stim_mem [MAX_RECS*REC_WORDS];
    word_t       shadow [`MEM_DEPTH];
    logic [15:0] lfsr_q;
    string       cur_test;

    always #CLK_HALF clk = ~clk;

    // Port names match the tb signals
    mem_subsys_top UUT (.*);

    // --------------------------------------------------
    // Failure reporting and compare tasks
    // --------------------------------------------------
    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s did not happen within %0d cycles",
                 cur_test, what, TIMEOUT_CYC);
        stop_run();
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_cycles(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // Shadow model and LFSR
    // --------------------------------------------------

    // Strobed bytes replaced and others kept
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < `MEM_BANKS; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = {val[30:0], lfsr_q[0]};
        end
    endtask

    // --------------------------------------------------
    // AXI master tasks entered and left 1 ns after an edge
    // --------------------------------------------------
    task automatic axi_write(input axi_addr_t addr, input word_t data, input strb_t strb,
                             input int stall);
        int waited;
        int lat;
        b_ready  = (stall == 0);
        aw_valid = 1'b1;
        aw_addr  = addr;
        w_valid  = 1'b1;
        w_data   = data;
        w_strb   = strb;
        waited   = 0;
        // Ready sampled mid-cycle before the handshake edge
        @(negedge clk);
        while (!(aw_ready && w_ready)) begin
            waited++;
            if (waited > TIMEOUT_CYC) begin
                report_timeout("AW/W handshake");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        shadow[addr[11:2]] = merge_bytes(shadow[addr[11:2]], data, strb);
        lat = 1;
        @(negedge clk);
        while (!b_valid) begin
            lat++;
            if (lat > TIMEOUT_CYC) begin
                report_timeout("B valid");
            end
            @(negedge clk);
        end
        check_cycles("AW/W to b_valid", B_LATENCY, lat);
        check_resp("BRESP", RESP_OKAY, b_resp);
        // Response must stay while B is held off
        if (stall > 0) begin
            for (int i = 0; i < stall; i++) begin
                @(negedge clk);
                check_flag("b_valid hold", 1'b1, b_valid);
            end
            @(posedge clk);
            #DRIVE_DLY;
            b_ready = 1'b1;
            @(negedge clk);
            check_flag("b_valid at handshake", 1'b1, b_valid);
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic axi_read(input axi_addr_t addr, input int stall, output word_t data);
        int waited;
        int lat;
        r_ready  = (stall == 0);
        ar_valid = 1'b1;
        ar_addr  = addr;
        waited   = 0;
        @(negedge clk);
        while (!ar_ready) begin
            waited++;
            if (waited > TIMEOUT_CYC) begin
                report_timeout("AR handshake");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        ar_valid = 1'b0;
        lat = 1;
        @(negedge clk);
        while (!r_valid) begin
            lat++;
            if (lat > TIMEOUT_CYC) begin
                report_timeout("R valid");
            end
            @(negedge clk);
        end
        check_cycles("AR to r_valid", R_LATENCY, lat);
        check_resp("RRESP", RESP_OKAY, r_resp);
        data = r_data;
        // Data holds and no read is taken while R is stalled
        if (stall > 0) begin
            for (int i = 0; i < stall; i++) begin
                @(negedge clk);
                check_flag("r_valid hold", 1'b1, r_valid);
                check_word("r_data hold", data, r_data);
                check_flag("ar_ready while R pending", 1'b0, ar_ready);
            end
            @(posedge clk);
            #DRIVE_DLY;
            r_ready = 1'b1;
            @(negedge clk);
            check_flag("r_valid at handshake", 1'b1, r_valid);
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        stim_rec_t   rec;
        word_t       rd;
        axi_addr_t   addr;
        logic [31:0] data_bits;
        logic [31:0] strb_bits;
        logic [31:0] stall_bits;
        int          base;
        rst_n    = 1'b0;
        aw_valid = 1'b0;
        aw_addr  = '0;
        w_valid  = 1'b0;
        w_data   = '0;
        w_strb   = '0;
        b_ready  = 1'b1;
        ar_valid = 1'b0;
        ar_addr  = '0;
        r_ready  = 1'b1;
        lfsr_q   = LFSR_SEED;
        cur_test = "reset";
        for (int i = 0; i < MAX_RECS*REC_WORDS; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("mem_testdata.txt", stim_mem);

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("b_valid", 1'b0, b_valid);
        check_flag("r_valid", 1'b0, r_valid);
        check_flag("aw_ready without valids", 1'b0, aw_ready);
        check_flag("ar_ready when idle", 1'b1, ar_ready);
        @(posedge clk);
        #DRIVE_DLY;

        // Full words, byte strobes and fixed latency
        cur_test = "testdata";
        for (int k = 0; k < MAX_RECS; k++) begin
            base         = k * REC_WORDS;
            rec.op       = stim_mem[base];
            rec.addr     = axi_addr_t'(stim_mem[base + 1]);
            rec.data     = stim_mem[base + 2];
            rec.strb     = strb_t'(stim_mem[base + 3]);
            rec.expected = stim_mem[base + 4];
            if (rec.op == OP_END) begin
                break;
            end else if (rec.op == OP_WRITE) begin
                axi_write(rec.addr, rec.data, rec.strb, 0);
            end else if (rec.op == OP_READ) begin
                axi_read(rec.addr, 0, rd);
                check_word("shadow vs file", rec.expected, shadow[rec.addr[11:2]]);
                check_word("read data", rec.expected, rd);
            end else begin
                $display("Bad operation code %0h in data file record %0d", rec.op, k);
                stop_run();
            end
        end

        // Random data, strobes and stalls
        cur_test = "random back-pressure";
        for (int n = 0; n < N_RANDOM; n++) begin
            take_bits(10, data_bits);
            addr = {data_bits[9:0], 2'b00};
            take_bits(32, data_bits);
            take_bits(3, stall_bits);
            axi_write(addr, data_bits, 4'hf, int'(stall_bits));
            take_bits(32, data_bits);
            take_bits(4, strb_bits);
            take_bits(3, stall_bits);
            axi_write(addr, data_bits, strb_t'(strb_bits), int'(stall_bits));
            take_bits(3, stall_bits);
            axi_read(addr, int'(stall_bits), rd);
            check_word("read vs shadow", shadow[addr[11:2]], rd);
        end

        // Write pair and read raised together
        cur_test = "contention";
        addr = 12'h010;
        axi_write(addr, 32'h0bad_cafe, 4'hf, 0);
        // R held off so a read taken ahead of the write stays visible
        r_ready  = 1'b0;
        ar_valid = 1'b1;
        ar_addr  = addr;
        axi_write(addr, 32'hc0de_5eed, 4'hf, 0);
        check_flag("r_valid before contended AR", 1'b0, r_valid);
        axi_read(addr, 0, rd);
        check_word("read after contended write", shadow[addr[11:2]], rd);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
mem_pkg.sv
sram_sp_1024x8.sv
dpram_1024x8.sv
axil_req_arbiter.sv
axil_read_return.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build for the AXI4-Lite word memory

SIM      := verilator
FLAGS    := --binary --timing
TOP      := tb_mem_subsys
FILELIST := build.f
OBJ_DIR  := obj_dir
PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== mem_testdata.txt ====
// Columns: op (1 write, 2 read, 0 end)  byte address  write data  strobe  expected read word
// Expected words apply the byte strobes of all earlier writes in this file
1 000 11223344 f 00000000
1 004 55667788 f 00000000
1 ffc deadbeef f 00000000
2 000 00000000 0 11223344
2 004 00000000 0 55667788
2 ffc 00000000 0 deadbeef
1 000 000000aa 1 00000000
2 000 00000000 0 112233aa
1 004 0000bb00 2 00000000
1 ffc 00cc0000 4 00000000
1 000 ee000000 8 00000000
1 004 12345678 5 00000000
2 004 00000000 0 5534bb78
2 ffc 00000000 0 deccbeef
2 000 00000000 0 ee2233aa
0 000 00000000 0 00000000
